//--- hdl/ptw_consts.svh
// Sv32 walker widths, PTE field sizes and satp bit positions
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// Data and address width
`define PTW_XLEN 32

// Virtual address fields
`define PTW_PGOFF_W 12
`define PTW_VPN_W 10

// Physical page number fields held in a PTE
`define PTW_PPN1_W 12
`define PTW_PPN0_W 10
`define PTW_PPN_W 22

// PTEs are 4 bytes
`define PTW_PTE_SHIFT 2

// satp layout
`define PTW_SATP_MODE_BIT 31

`endif

//--- hdl/ptw_pkg.sv
// Request, response, PTE, privilege and fault types for the Sv32 walker
`default_nettype none

`include "ptw_consts.svh"

package ptw_pkg;

    typedef enum logic [1:0] {
        priv_u = 2'b00,
        priv_s = 2'b01,
        priv_m = 2'b11
    } priv_mode_t;

    typedef enum logic {
        fault_access = 1'b0,
        fault_page   = 1'b1
    } fault_t;

    typedef struct packed {
        logic                 valid;
        logic [`PTW_XLEN-1:0] addr;
        logic                 wen;
        logic [`PTW_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`PTW_XLEN-1:0] rdata;
        logic                 error;
        fault_t               errty;
    } mem_resp_t;

    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    // Whole number for pointers and level 0, split pair for superpages
    typedef union packed {
        logic [`PTW_PPN_W-1:0] num;
        struct packed {
            logic [`PTW_PPN1_W-1:0] ppn1;
            logic [`PTW_PPN0_W-1:0] ppn0;
        } part;
    } pte_ppn_u;

    typedef struct packed {
        pte_ppn_u   ppn;
        logic [1:0] rsw;
        pte_flags_t flags;
    } pte_t;

    typedef struct packed {
        logic [`PTW_VPN_W-1:0]   vpn1;
        logic [`PTW_VPN_W-1:0]   vpn0;
        logic [`PTW_PGOFF_W-1:0] pgoff;
    } vaddr_t;

    typedef enum logic [1:0] {
        pte_pointer,
        pte_leaf,
        pte_page_fault,
        pte_access_fault
    } pte_class_t;

endpackage

`default_nettype wire

//--- hdl/pte_check.sv
// PTE classifier: next-level pointer, leaf, page fault or access fault
`timescale 1ns/100ps
`default_nettype none

module pte_check #(
    parameter int exec_mode = 0
) (
    input  wire ptw_pkg::pte_t       pte,
    input  wire                      level,
    input  wire                      wen,
    input  wire                      error,
    input  wire ptw_pkg::priv_mode_t mode,
    input  wire                      mxr,
    input  wire                      sum,
    output ptw_pkg::pte_class_t      pte_class
);

    logic leaf;
    logic perm_ok;
    logic user_fault;
    logic format_fault;
    logic page_fault;

    always_comb begin
        leaf = pte.flags.r | pte.flags.w | pte.flags.x;

        // Permission needed by this access
        if (exec_mode != 0) begin
            perm_ok = pte.flags.x;
        end else if (wen) begin
            perm_ok = pte.flags.w;
        end else begin
            perm_ok = pte.flags.r | (mxr & pte.flags.x);
        end

        // Fetch from a user page is never allowed in S-mode
        user_fault = (mode == ptw_pkg::priv_s) & pte.flags.u & ((exec_mode != 0) | !sum);

        format_fault = !pte.flags.v
                     | (pte.flags.w & !pte.flags.r)
                     | pte.flags.g
                     | (!leaf & (pte.flags.a | pte.flags.d))
                     | (!leaf & !level);

        // Misaligned superpage
        page_fault = format_fault
                   | user_fault
                   | (leaf & level & (pte.ppn.part.ppn0 != '0))
                   | (leaf & !perm_ok)
                   | (leaf & (!pte.flags.a | (wen & !pte.flags.d)));

        if (error) begin
            pte_class = ptw_pkg::pte_access_fault;
        end else if (page_fault) begin
            pte_class = ptw_pkg::pte_page_fault;
        end else if (leaf) begin
            pte_class = ptw_pkg::pte_leaf;
        end else begin
            pte_class = ptw_pkg::pte_pointer;
        end
    end

endmodule

`default_nettype wire

//--- hdl/walk_control.sv
// Walk FSM with saved request, PTE and physical address forming, and result capture
`timescale 1ns/100ps
`default_nettype none

`include "ptw_consts.svh"

module walk_control (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      translate,
    input  wire [`PTW_PPN_W-1:0]     satp_ppn,
    input  wire ptw_pkg::mem_req_t   preq,
    input  wire ptw_pkg::pte_class_t pte_class,
    input  wire ptw_pkg::mem_resp_t  pteresp,
    input  wire                      mem_ready,
    input  wire ptw_pkg::mem_resp_t  memresp,
    input  wire                      pte_ready,
    output logic                     walk_idle,
    output logic                     level,
    output ptw_pkg::mem_req_t        saved_req,
    output ptw_pkg::pte_t            walk_pte,
    output logic                     ptereq_valid,
    output logic [`PTW_XLEN-1:0]     ptereq_addr,
    output ptw_pkg::mem_req_t        walk_memreq,
    output logic                     walk_done,
    output ptw_pkg::mem_resp_t       walk_result
);

    // Physical addresses are 32 bits, so the top PPN bits are dropped
    localparam int PA_PPN_W  = `PTW_XLEN - `PTW_PGOFF_W;
    localparam int PA_PPN1_W = PA_PPN_W - `PTW_PPN0_W;

    typedef enum logic [2:0] {
        st_idle,
        st_walk_req,
        st_walk_wait,
        st_mem_req,
        st_mem_wait,
        st_done
    } state_t;

    state_t state;

    ptw_pkg::vaddr_t      req_va;
    ptw_pkg::vaddr_t      saved_va;
    logic [`PTW_XLEN-1:0] next_addr;
    logic [`PTW_XLEN-1:0] l1_pte_addr;
    logic [`PTW_XLEN-1:0] l0_pte_addr;
    logic [`PTW_XLEN-1:0] leaf_paddr;
    logic                 accept;
    logic                 pte_take;
    logic                 mem_take;

    assign req_va   = preq.addr;
    assign saved_va = saved_req.addr;
    assign walk_pte = pteresp.rdata;

    assign accept   = (state == st_idle) & translate & preq.valid;
    assign pte_take = (state == st_walk_wait) & pteresp.valid;
    assign mem_take = (state == st_mem_wait) & memresp.valid;

    always_comb begin
        l1_pte_addr = {satp_ppn[PA_PPN_W-1:0], req_va.vpn1, {`PTW_PTE_SHIFT{1'b0}}};
        l0_pte_addr = {walk_pte.ppn.num[PA_PPN_W-1:0], saved_va.vpn0,
                       {`PTW_PTE_SHIFT{1'b0}}};
        if (level) begin
            // Superpage keeps vpn0 from the virtual address
            leaf_paddr = {walk_pte.ppn.part.ppn1[PA_PPN1_W-1:0], saved_va.vpn0,
                          saved_va.pgoff};
        end else begin
            leaf_paddr = {walk_pte.ppn.num[PA_PPN_W-1:0], saved_va.pgoff};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_walk_req;
                    end
                end
                st_walk_req: begin
                    if (pte_ready) begin
                        state <= st_walk_wait;
                    end
                end
                st_walk_wait: begin
                    if (pteresp.valid) begin
                        case (pte_class)
                            ptw_pkg::pte_pointer: state <= st_walk_req;
                            ptw_pkg::pte_leaf:    state <= st_mem_req;
                            default:              state <= st_done;
                        endcase
                    end
                end
                st_mem_req: begin
                    if (mem_ready) begin
                        state <= st_mem_wait;
                    end
                end
                st_mem_wait: begin
                    if (memresp.valid) begin
                        state <= st_done;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // Request, walk address and result payload
    always_ff @(posedge clk) begin
        if (accept) begin
            saved_req <= preq;
            level     <= 1'b1;
            next_addr <= l1_pte_addr;
        end
        if (pte_take) begin
            case (pte_class)
                ptw_pkg::pte_pointer: begin
                    level     <= 1'b0;
                    next_addr <= l0_pte_addr;
                end
                ptw_pkg::pte_leaf: next_addr <= leaf_paddr;
                default: begin
                    walk_result <= '{
                        valid: 1'b1,
                        rdata: '0,
                        error: 1'b1,
                        errty: (pte_class == ptw_pkg::pte_access_fault) ?
                               ptw_pkg::fault_access : ptw_pkg::fault_page
                    };
                end
            endcase
        end
        if (mem_take) begin
            walk_result <= '{
                valid: 1'b1,
                rdata: memresp.rdata,
                error: memresp.error,
                errty: memresp.errty
            };
        end
    end

    assign walk_idle    = state == st_idle;
    assign walk_done    = state == st_done;
    assign ptereq_valid = state == st_walk_req;
    assign ptereq_addr  = next_addr;

    assign walk_memreq = '{
        valid: state == st_mem_req,
        addr:  next_addr,
        wen:   saved_req.wen,
        wdata: saved_req.wdata
    };

endmodule

`default_nettype wire

//--- hdl/resp_select.sv
// Bare or translated selection of memory traffic and the processor response
`timescale 1ns/100ps
`default_nettype none

module resp_select (
    input  wire                     translate,
    input  wire ptw_pkg::mem_req_t  preq,
    input  wire ptw_pkg::mem_resp_t memresp,
    input  wire                     walk_idle,
    input  wire ptw_pkg::mem_req_t  walk_memreq,
    input  wire                     walk_done,
    input  wire ptw_pkg::mem_resp_t walk_result,
    input  wire                     mem_ready,
    output ptw_pkg::mem_req_t       memreq,
    output ptw_pkg::mem_resp_t      presp,
    output logic                    preq_ready
);

    always_comb begin
        if (translate) begin
            memreq      = walk_memreq;
            preq_ready  = walk_idle;
            presp       = walk_result;
            // Result is only meaningful in the done cycle
            presp.valid = walk_done;
        end else begin
            // Bare mode passes straight through
            memreq     = preq;
            preq_ready = mem_ready;
            presp      = memresp;
        end
    end

endmodule

`default_nettype wire

//--- hdl/page_table_walker.sv
// Sv32 page table walker top: PTE checker, walk FSM and response select
`timescale 1ns/100ps
`default_nettype none

`include "ptw_consts.svh"

module page_table_walker #(
    parameter int exec_mode = 0
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire ptw_pkg::mem_req_t   preq,
    output logic                     preq_ready,
    output ptw_pkg::mem_resp_t       presp,
    input  wire ptw_pkg::priv_mode_t mode,
    input  wire [`PTW_XLEN-1:0]      satp,
    input  wire                      mxr,
    input  wire                      sum,
    output ptw_pkg::mem_req_t        memreq,
    input  wire                      mem_ready,
    input  wire ptw_pkg::mem_resp_t  memresp,
    output logic                     ptereq_valid,
    output logic [`PTW_XLEN-1:0]     ptereq_addr,
    input  wire                      pte_ready,
    input  wire ptw_pkg::mem_resp_t  pteresp
);

    logic                translate;
    logic                walk_idle;
    logic                level;
    logic                walk_done;
    ptw_pkg::mem_req_t   saved_req;
    ptw_pkg::mem_req_t   walk_memreq;
    ptw_pkg::mem_resp_t  walk_result;
    ptw_pkg::pte_t       walk_pte;
    ptw_pkg::pte_class_t pte_class;

    // M-mode always runs untranslated
    assign translate = satp[`PTW_SATP_MODE_BIT] & (mode != ptw_pkg::priv_m);

    pte_check #(
        .exec_mode(exec_mode)
    ) u_pte_check (
        .pte      (walk_pte),
        .level    (level),
        .wen      (saved_req.wen),
        .error    (pteresp.error),
        .mode     (mode),
        .mxr      (mxr),
        .sum      (sum),
        .pte_class(pte_class)
    );

    walk_control u_walk_control (
        .clk         (clk),
        .reset       (reset),
        .translate   (translate),
        .satp_ppn    (satp[`PTW_PPN_W-1:0]),
        .preq        (preq),
        .pte_class   (pte_class),
        .pteresp     (pteresp),
        .mem_ready   (mem_ready),
        .memresp     (memresp),
        .pte_ready   (pte_ready),
        .walk_idle   (walk_idle),
        .level       (level),
        .saved_req   (saved_req),
        .walk_pte    (walk_pte),
        .ptereq_valid(ptereq_valid),
        .ptereq_addr (ptereq_addr),
        .walk_memreq (walk_memreq),
        .walk_done   (walk_done),
        .walk_result (walk_result)
    );

    resp_select u_resp_select (
        .translate  (translate),
        .preq       (preq),
        .memresp    (memresp),
        .walk_idle  (walk_idle),
        .walk_memreq(walk_memreq),
        .walk_done  (walk_done),
        .walk_result(walk_result),
        .mem_ready  (mem_ready),
        .memreq     (memreq),
        .presp      (presp),
        .preq_ready (preq_ready)
    );

endmodule

`default_nettype wire

//--- verif/ptw_mem_model.sv
// Page-table and data memory responder with LFSR-random ready and response latency
`timescale 1ns/100ps
`default_nettype none

`include "ptw_consts.svh"

module ptw_mem_model (
    input  wire                    clk,
    input  wire [`PTW_XLEN-1:0]    pte1_addr,
    input  wire [`PTW_XLEN-1:0]    pte1_word,
    input  wire [`PTW_XLEN-1:0]    pte0_addr,
    input  wire [`PTW_XLEN-1:0]    pte0_word,
    input  wire [1:0]              pte_err,
    input  wire [`PTW_XLEN-1:0]    mem_rdata,
    input  wire [1:0]              mem_err,
    input  wire                    ptereq_valid,
    input  wire [`PTW_XLEN-1:0]    ptereq_addr,
    output logic                   pte_ready,
    output ptw_pkg::mem_resp_t     pteresp,
    input  wire ptw_pkg::mem_req_t memreq,
    output logic                   mem_ready,
    output ptw_pkg::mem_resp_t     memresp,
    output ptw_pkg::mem_req_t      last_req,
    output int                     mem_count,
    output logic                   pte_miss
);

    logic [31:0]          lfsr;
    logic                 pte_fire;
    logic                 mem_fire;
    logic [`PTW_XLEN-1:0] pte_addr_q;
    int                   pte_delay;
    int                   mem_delay;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(output logic [1:0] bits);
        for (int i = 0; i < 2; i++) begin
            bits[i] = lfsr[0];
            lfsr    = lfsr_next(lfsr);
        end
    endtask

    initial begin
        lfsr       = 32'd96436;
        pte_ready  = 1'b0;
        pteresp    = '0;
        mem_ready  = 1'b0;
        memresp    = '0;
        last_req   = '0;
        mem_count  = 0;
        pte_miss   = 1'b0;
        pte_fire   = 1'b0;
        mem_fire   = 1'b0;
        pte_addr_q = '0;
        pte_delay  = -1;
        mem_delay  = -1;
    end

    // Transfers happen on the rising edge
    always @(posedge clk) begin
        pte_fire <= ptereq_valid & pte_ready;
        mem_fire <= memreq.valid & mem_ready;
        if (ptereq_valid & pte_ready) begin
            pte_addr_q <= ptereq_addr;
        end
        if (memreq.valid & mem_ready) begin
            last_req  <= memreq;
            mem_count <= mem_count + 1;
        end
    end

    always @(negedge clk) begin
        logic [1:0] bits;
        pteresp.valid = 1'b0;
        memresp.valid = 1'b0;
        if (pte_fire) begin
            take_bits(bits);
            pte_delay = bits;
        end
        if (mem_fire) begin
            take_bits(bits);
            mem_delay = bits;
        end
        if (pte_delay == 0) begin
            if (pte_addr_q == pte1_addr) begin
                pteresp = '{valid: 1'b1, rdata: pte1_word, error: pte_err[1],
                            errty: ptw_pkg::fault_access};
            end else if (pte_addr_q == pte0_addr) begin
                pteresp = '{valid: 1'b1, rdata: pte0_word, error: pte_err[0],
                            errty: ptw_pkg::fault_access};
            end else begin
                // Walk read an address outside this vector's table
                pteresp  = '{valid: 1'b1, rdata: '0, error: 1'b0,
                             errty: ptw_pkg::fault_access};
                pte_miss = 1'b1;
            end
        end
        if (mem_delay == 0) begin
            memresp = '{valid: 1'b1, rdata: mem_rdata, error: mem_err[0],
                        errty: ptw_pkg::fault_t'(mem_err[1])};
        end
        if (pte_delay >= 0) begin
            pte_delay = pte_delay - 1;
        end
        if (mem_delay >= 0) begin
            mem_delay = mem_delay - 1;
        end
        take_bits(bits);
        pte_ready = |bits;
        take_bits(bits);
        mem_ready = |bits;
    end

endmodule

`default_nettype wire

//--- verif/ptw_tb.sv
// Walker testbench: clock, reset, vector replay, response checks and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "ptw_consts.svh"

module ptw_tb;

    localparam int NUM_VEC  = 17;
    localparam int VEC_COLS = 10;

    logic                 clk;
    logic                 reset;
    ptw_pkg::mem_req_t    preq;
    logic                 preq_ready;
    ptw_pkg::mem_resp_t   presp;
    ptw_pkg::priv_mode_t  mode;
    logic [`PTW_XLEN-1:0] satp;
    logic                 mxr;
    logic                 sum;
    ptw_pkg::mem_req_t    memreq;
    logic                 mem_ready;
    ptw_pkg::mem_resp_t   memresp;
    logic                 ptereq_valid;
    logic [`PTW_XLEN-1:0] ptereq_addr;
    logic                 pte_ready;
    ptw_pkg::mem_resp_t   pteresp;
    logic [`PTW_XLEN-1:0] pte1_addr;
    logic [`PTW_XLEN-1:0] pte1_word;
    logic [`PTW_XLEN-1:0] pte0_addr;
    logic [`PTW_XLEN-1:0] pte0_word;
    logic [1:0]           pte_err;
    logic [`PTW_XLEN-1:0] mem_rdata;
    logic [1:0]           mem_err;
    ptw_pkg::mem_req_t    last_req;
    int                   mem_count;
    logic                 pte_miss;
    logic [`PTW_XLEN-1:0] vectors [0:NUM_VEC*VEC_COLS-1];

    always #5 clk = ~clk;

    page_table_walker #(
        .exec_mode(0)
    ) dut0 (
        .clk(clk), .reset(reset), .preq(preq), .preq_ready(preq_ready), .presp(presp),
        .mode(mode), .satp(satp), .mxr(mxr), .sum(sum), .memreq(memreq),
        .mem_ready(mem_ready), .memresp(memresp), .ptereq_valid(ptereq_valid),
        .ptereq_addr(ptereq_addr), .pte_ready(pte_ready), .pteresp(pteresp)
    );

    ptw_mem_model mem0 (
        .clk(clk), .pte1_addr(pte1_addr), .pte1_word(pte1_word), .pte0_addr(pte0_addr),
        .pte0_word(pte0_word), .pte_err(pte_err), .mem_rdata(mem_rdata), .mem_err(mem_err),
        .ptereq_valid(ptereq_valid), .ptereq_addr(ptereq_addr), .pte_ready(pte_ready),
        .pteresp(pteresp), .memreq(memreq), .mem_ready(mem_ready), .memresp(memresp),
        .last_req(last_req), .mem_count(mem_count), .pte_miss(pte_miss)
    );

    task automatic check_value(input string name, input logic [`PTW_XLEN-1:0] got,
                               input logic [`PTW_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic run_vector(input int idx);
        int                   base;
        int                   count_before;
        logic                 translate;
        logic [`PTW_XLEN-1:0] ctrl;
        logic [`PTW_XLEN-1:0] flt;
        ptw_pkg::vaddr_t      va;
        ptw_pkg::pte_t        pte1;
        ptw_pkg::mem_resp_t   resp;
        base = idx * VEC_COLS;
        ctrl = vectors[base];
        va   = vectors[base + 2];
        pte1 = vectors[base + 4];
        flt  = vectors[base + 9];

        @(negedge clk);
        mode      = ptw_pkg::priv_mode_t'(ctrl[29:28]);
        mxr       = ctrl[24];
        sum       = ctrl[20];
        satp      = vectors[base + 1];
        preq      = '{valid: 1'b1, addr: va, wen: ctrl[16], wdata: vectors[base + 3]};
        pte1_word = pte1;
        pte0_word = vectors[base + 5];
        pte_err   = {ctrl[12], ctrl[8]};
        mem_rdata = vectors[base + 6];
        mem_err   = ctrl[5:4];
        // Table base page plus index times PTE size, in a 32-bit physical space
        pte1_addr = (satp[`PTW_PPN_W-1:0] << `PTW_PGOFF_W) + (va.vpn1 << `PTW_PTE_SHIFT);
        pte0_addr = (pte1.ppn.num << `PTW_PGOFF_W) + (va.vpn0 << `PTW_PTE_SHIFT);
        translate = satp[`PTW_SATP_MODE_BIT] && (mode != ptw_pkg::priv_m);
        count_before = mem_count;

        do begin
            @(posedge clk);
        end while (!preq_ready);
        @(negedge clk);
        preq.valid = 1'b0;

        @(posedge clk);
        while (!presp.valid) begin
            if (translate) begin
                check_value("preq_ready", preq_ready, 32'h0);
            end
            @(posedge clk);
        end
        resp = presp;

        check_value("presp.rdata", resp.rdata, vectors[base + 8]);
        check_value("presp.error", resp.error, flt[4]);
        check_value("presp.errty", resp.errty, flt[0]);
        check_value("memory access count", mem_count - count_before, flt[8]);
        if (flt[8]) begin
            check_value("memreq.addr", last_req.addr, vectors[base + 7]);
            check_value("memreq.wen", last_req.wen, ctrl[16]);
            check_value("memreq.wdata", last_req.wdata, vectors[base + 3]);
        end
        check_value("pte address miss", pte_miss, 32'h0);

        // Only one response per request
        repeat (2) begin
            @(posedge clk);
            check_value("presp.valid", presp.valid, 32'h0);
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        preq      = '0;
        mode      = ptw_pkg::priv_m;
        satp      = '0;
        mxr       = 1'b0;
        sum       = 1'b0;
        pte1_addr = '0;
        pte1_word = '0;
        pte0_addr = '0;
        pte0_word = '0;
        pte_err   = '0;
        mem_rdata = '0;
        mem_err   = '0;
        $readmemh("verif/ptw_vectors.txt", vectors);
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < NUM_VEC; i++) begin
            run_vector(i);
        end
        $display("All tests passed!");
        $finish;
    end

    initial begin
        repeat (8 + NUM_VEC * 200) @(posedge clk);
        $display("Watchdog expired: the vectors did not finish within %0d cycles",
                 NUM_VEC * 200);
        $display("Test failures found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- verif/ptw_vectors.txt
// ctrl digits: mode mxr sum wen pte1_err pte0_err mem_err(errty,error) 0
// ctrl satp va wdata pte1 pte0 mdata exp_addr exp_rdata exp(access error errty)
10000000 00000080 12345678 00000000 00000000 00000000 cafe0001 12345678 cafe0001 00000100
30010000 80000080 00400010 a5a55a5a 00000000 00000000 00000000 00400010 00000000 00000100
10000010 00000080 00400020 00000000 00000000 00000000 beef0001 00400020 beef0001 00000110
00000000 80000080 12345678 00000000 00024001 0002acc7 11112222 000ab678 11112222 00000100
10010000 80000080 12345678 33334444 00024001 0002acc7 00000000 000ab678 00000000 00000100
10000000 80000080 12345678 00000000 005000c7 00000000 55556666 01745678 55556666 00000100
10000000 80000080 12345678 00000000 005004c7 00000000 00000000 00000000 00000000 00000011
10000000 80000080 12345678 00000000 00024001 0002acd7 00000000 00000000 00000000 00000011
10010000 80000080 12345678 33334444 00024001 0002ac43 00000000 00000000 00000000 00000011
10000000 80000080 12345678 00000000 00024001 0002ac49 00000000 00000000 00000000 00000011
11000000 80000080 12345678 00000000 00024001 0002ac49 77778888 000ab678 77778888 00000100
10000000 80000080 12345678 00000000 00024001 0002acc6 00000000 00000000 00000000 00000011
10000000 80000080 12345678 00000000 00024001 0002ac87 00000000 00000000 00000000 00000011
10001000 80000080 12345678 00000000 00024001 0002acc7 00000000 00000000 00000000 00000010
10000100 80000080 12345678 00000000 00024001 0002acc7 00000000 00000000 00000000 00000010
10000030 80000080 12345678 00000000 00024001 0002acc7 dead0003 000ab678 dead0003 00000111
10100000 80000080 12345678 00000000 00024001 0002acd7 9999aaaa 000ab678 9999aaaa 00000100

//--- filelist.f
+incdir+hdl
hdl/ptw_pkg.sv
hdl/pte_check.sv
hdl/walk_control.sv
hdl/resp_select.sv
hdl/page_table_walker.sv
verif/ptw_mem_model.sv
verif/ptw_tb.sv
